// File: core_axi_subsystem.f
src/axi_defs_pkg.sv
src/core_port_pkg.sv
src/axi_bus_if.sv
src/sync_fifo.sv
src/axi_master_adapter.sv
src/axi_atomic_mem.sv
src/core_axi_subsystem.sv
tests/tb_core_axi_subsystem.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f core_axi_subsystem.f \
  --top-module tb_core_axi_subsystem -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF "FAIL: see errors above" sim.log || ! grep -qF "PASS: all tests" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// File: src/axi_atomic_mem.sv
`default_nettype none
// AXI4 slave memory with atomic transactions
// Single-beat writes and atomics, incrementing read bursts,
// SLVERR for anything past the end of the array

module axi_atomic_mem #(
  parameter int unsigned Words = 64
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  axi_bus_if.slave axi
);

  localparam int unsigned WordBytes  = axi_defs_pkg::AxiDataWidth / 8;
  localparam int unsigned ByteOffset = $clog2(WordBytes);
  localparam int unsigned IdxWidth   = (Words > 1) ? $clog2(Words) : 1;
  localparam int unsigned LaneWidth  = 32;
  localparam int unsigned Lanes      = axi_defs_pkg::AxiDataWidth / LaneWidth;

  typedef logic [IdxWidth-1:0]  idx_t;
  typedef logic [LaneWidth-1:0] lane_t;
  typedef enum logic {Idle, Burst} rd_state_e;

  axi_defs_pkg::axi_data_t mem_q [Words];
  logic                    aw_pending_q;
  axi_defs_pkg::axi_addr_t aw_addr_q;
  axi_defs_pkg::axi_atop_t aw_atop_q;
  rd_state_e               state_q;
  axi_defs_pkg::axi_addr_t rd_addr_q;
  axi_defs_pkg::axi_len_t  rd_cnt_q;
  logic                    aw_is_atomic;
  logic                    w_fire;
  logic                    rd_load;
  logic                    wr_ok;
  logic                    rd_ok;
  axi_defs_pkg::axi_data_t old_word;
  axi_defs_pkg::axi_data_t amo_word;
  axi_defs_pkg::axi_data_t new_word;

  function automatic logic in_range(axi_defs_pkg::axi_addr_t addr);
    return addr[axi_defs_pkg::AxiAddrWidth-1:ByteOffset] < Words;
  endfunction

  function automatic idx_t word_idx(axi_defs_pkg::axi_addr_t addr);
    return addr[ByteOffset +: IdxWidth];
  endfunction

  // Result of one 32-bit lane
  // Plain writes and swap store the operand
  function automatic lane_t amo_lane(axi_defs_pkg::axi_atop_t atop, lane_t old_v, lane_t opd);
    lane_t res;
    res = opd;
    if (atop[5:4] == axi_defs_pkg::AtopAtomicLoad) begin
      unique case (atop[2:0])
        axi_defs_pkg::AtopAdd:  res = old_v + opd;
        axi_defs_pkg::AtopClr:  res = old_v & ~opd;
        axi_defs_pkg::AtopEor:  res = old_v ^ opd;
        axi_defs_pkg::AtopSet:  res = old_v | opd;
        axi_defs_pkg::AtopSmax: res = ($signed(old_v) > $signed(opd)) ? old_v : opd;
        axi_defs_pkg::AtopSmin: res = ($signed(old_v) < $signed(opd)) ? old_v : opd;
        axi_defs_pkg::AtopUmax: res = (old_v > opd) ? old_v : opd;
        axi_defs_pkg::AtopUmin: res = (old_v < opd) ? old_v : opd;
      endcase
    end
    return res;
  endfunction

  assign aw_is_atomic = (aw_atop_q != '0);
  assign wr_ok        = in_range(aw_addr_q);
  assign rd_ok        = in_range(rd_addr_q);
  assign old_word     = mem_q[word_idx(aw_addr_q)];

  assign axi.aw_ready = ~aw_pending_q;
  // An atomic needs the R channel to itself
  assign axi.w_ready  = aw_pending_q & ~axi.b_valid
                        & (~aw_is_atomic | ((state_q == Idle) & ~axi.r_valid));
  assign axi.ar_ready = (state_q == Idle) & ~axi.r_valid & ~(aw_pending_q & aw_is_atomic);

  assign w_fire  = axi.w_valid & axi.w_ready;
  assign rd_load = (state_q == Burst) & (~axi.r_valid | axi.r_ready);

  always_comb begin
    for (int l = 0; l < Lanes; l++) begin
      amo_word[l*LaneWidth +: LaneWidth] = amo_lane(aw_atop_q,
          old_word[l*LaneWidth +: LaneWidth], axi.w_data[l*LaneWidth +: LaneWidth]);
    end
    for (int b = 0; b < WordBytes; b++) begin
      new_word[b*8 +: 8] = axi.w_strb[b] ? amo_word[b*8 +: 8] : old_word[b*8 +: 8];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      aw_pending_q <= 1'b0;
      aw_addr_q    <= '0;
      aw_atop_q    <= '0;
      state_q      <= Idle;
      rd_addr_q    <= '0;
      rd_cnt_q     <= '0;
      axi.b_valid  <= 1'b0;
      axi.b_resp   <= axi_defs_pkg::RespOkay;
      axi.r_valid  <= 1'b0;
      axi.r_data   <= '0;
      axi.r_resp   <= axi_defs_pkg::RespOkay;
      axi.r_last   <= 1'b0;
      for (int i = 0; i < Words; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (axi.aw_valid && axi.aw_ready) begin
        aw_pending_q <= 1'b1;
        aw_addr_q    <= axi.aw_addr;
        aw_atop_q    <= axi.aw_atop;
      end
      if (axi.b_valid && axi.b_ready) begin
        axi.b_valid <= 1'b0;
      end
      if (axi.r_valid && axi.r_ready) begin
        axi.r_valid <= 1'b0;
      end
      if (w_fire) begin
        aw_pending_q <= 1'b0;
        axi.b_valid  <= 1'b1;
        axi.b_resp   <= wr_ok ? axi_defs_pkg::RespOkay : axi_defs_pkg::RespSlverr;
        if (wr_ok) begin
          mem_q[word_idx(aw_addr_q)] <= new_word;
        end
        if (aw_is_atomic) begin
          axi.r_valid <= 1'b1;
          axi.r_data  <= wr_ok ? old_word : '0;
          axi.r_resp  <= wr_ok ? axi_defs_pkg::RespOkay : axi_defs_pkg::RespSlverr;
          axi.r_last  <= 1'b1;
        end
      end
      unique case (state_q)
        Idle: begin
          if (axi.ar_valid && axi.ar_ready) begin
            state_q   <= Burst;
            rd_addr_q <= axi.ar_addr;
            rd_cnt_q  <= axi.ar_len;
          end
        end
        Burst: begin
          if (rd_load) begin
            axi.r_valid <= 1'b1;
            axi.r_data  <= rd_ok ? mem_q[word_idx(rd_addr_q)] : '0;
            axi.r_resp  <= rd_ok ? axi_defs_pkg::RespOkay : axi_defs_pkg::RespSlverr;
            axi.r_last  <= (rd_cnt_q == '0);
            // One full 64-bit word per beat
            rd_addr_q   <= rd_addr_q + axi_defs_pkg::axi_addr_t'(WordBytes);
            rd_cnt_q    <= rd_cnt_q - 1'b1;
            if (rd_cnt_q == '0) begin
              state_q <= Idle;
            end
          end
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Master only shows W after its AW has been taken
  a_w_after_aw : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    axi.w_valid |-> aw_pending_q);

endmodule

`default_nettype wire

// File: src/axi_bus_if.sv
`default_nettype none
// AXI4 bus with atomic transactions
// Five channels, single ID, master and slave views

interface axi_bus_if;

  axi_defs_pkg::axi_addr_t  aw_addr;
  axi_defs_pkg::axi_size_t  aw_size;
  axi_defs_pkg::axi_len_t   aw_len;
  axi_defs_pkg::axi_burst_t aw_burst;
  axi_defs_pkg::axi_atop_t  aw_atop;
  logic                     aw_valid;
  logic                     aw_ready;

  axi_defs_pkg::axi_data_t  w_data;
  axi_defs_pkg::axi_strb_t  w_strb;
  logic                     w_last;
  logic                     w_valid;
  logic                     w_ready;

  axi_defs_pkg::axi_resp_t  b_resp;
  logic                     b_valid;
  logic                     b_ready;

  axi_defs_pkg::axi_addr_t  ar_addr;
  axi_defs_pkg::axi_size_t  ar_size;
  axi_defs_pkg::axi_len_t   ar_len;
  axi_defs_pkg::axi_burst_t ar_burst;
  logic                     ar_valid;
  logic                     ar_ready;

  axi_defs_pkg::axi_data_t  r_data;
  axi_defs_pkg::axi_resp_t  r_resp;
  logic                     r_last;
  logic                     r_valid;
  logic                     r_ready;

  modport master (
    output aw_addr, aw_size, aw_len, aw_burst, aw_atop, aw_valid, input aw_ready,
    output w_data, w_strb, w_last, w_valid, input w_ready,
    input  b_resp, b_valid, output b_ready,
    output ar_addr, ar_size, ar_len, ar_burst, ar_valid, input ar_ready,
    input  r_data, r_resp, r_last, r_valid, output r_ready
  );

  modport slave (
    input  aw_addr, aw_size, aw_len, aw_burst, aw_atop, aw_valid, output aw_ready,
    input  w_data, w_strb, w_last, w_valid, output w_ready,
    output b_resp, b_valid, input b_ready,
    input  ar_addr, ar_size, ar_len, ar_burst, ar_valid, output ar_ready,
    output r_data, r_resp, r_last, r_valid, input r_ready
  );

endinterface

`default_nettype wire

// File: src/axi_defs_pkg.sv
`default_nettype none
// AXI4 bus definitions
// Payload widths, burst and response codes, atomic transaction encodings

package axi_defs_pkg;

  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 64;

  typedef logic [AxiAddrWidth-1:0]   axi_addr_t;
  typedef logic [AxiDataWidth-1:0]   axi_data_t;
  typedef logic [AxiDataWidth/8-1:0] axi_strb_t;
  typedef logic [7:0]                axi_len_t;
  typedef logic [2:0]                axi_size_t;
  typedef logic [1:0]                axi_burst_t;
  typedef logic [1:0]                axi_resp_t;
  typedef logic [5:0]                axi_atop_t;

  localparam axi_burst_t BurstIncr = 2'b01;

  localparam axi_resp_t RespOkay   = 2'b00;
  localparam axi_resp_t RespExokay = 2'b01;
  localparam axi_resp_t RespSlverr = 2'b10;

  // atop[5:4] kind, atop[3] endianness, atop[2:0] operation
  localparam logic [1:0] AtopAtomicLoad = 2'b10;
  localparam logic       AtopLittleEnd  = 1'b0;

  localparam logic [2:0] AtopAdd  = 3'b000;
  localparam logic [2:0] AtopClr  = 3'b001;
  localparam logic [2:0] AtopEor  = 3'b010;
  localparam logic [2:0] AtopSet  = 3'b011;
  localparam logic [2:0] AtopSmax = 3'b100;
  localparam logic [2:0] AtopSmin = 3'b101;
  localparam logic [2:0] AtopUmax = 3'b110;
  localparam logic [2:0] AtopUmin = 3'b111;

  localparam axi_atop_t AtopSwap = 6'b110000;

endpackage

`default_nettype wire

// File: src/axi_master_adapter.sv
`default_nettype none
// Core memory port to AXI4 master
// Steers narrow write data into its bus lane, maps RISC-V atomics to AXI
// atomic transactions and shifts read data back to the core width

module axi_master_adapter #(
  parameter int unsigned WriteFifoDepth = 2,
  parameter int unsigned ReadFifoDepth  = 2
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  axi_defs_pkg::axi_addr_t   q_addr_i,
  input  logic                      q_write_i,
  input  core_port_pkg::amo_op_t    q_amo_i,
  input  core_port_pkg::core_data_t q_data_i,
  input  core_port_pkg::core_strb_t q_strb_i,
  input  axi_defs_pkg::axi_size_t   q_size_i,
  input  axi_defs_pkg::axi_len_t    q_rlen_i,
  input  logic                      q_valid_i,
  output logic                      q_ready_o,
  output core_port_pkg::core_data_t p_data_o,
  output logic                      p_error_o,
  output logic                      p_last_o,
  output logic                      p_valid_o,
  input  logic                      p_ready_i,
  axi_bus_if.master                 axi
);

  localparam int unsigned AxiByteOffset = $clog2(axi_defs_pkg::AxiDataWidth / 8);
  localparam int unsigned LaneBits      = AxiByteOffset - core_port_pkg::CoreByteOffset;

  typedef logic [LaneBits-1:0] lane_t;

  typedef struct packed {
    core_port_pkg::core_data_t data;
    core_port_pkg::core_strb_t strb;
    lane_t                     lane;
  } wentry_t;

  logic    is_amo;
  logic    uses_aw;
  logic    uses_shift;
  logic    q_fire;
  logic    wfifo_full;
  logic    wfifo_empty;
  logic    rfifo_full;
  wentry_t wfifo_in;
  wentry_t wfifo_out;
  lane_t   r_lane;

  assign is_amo     = (q_amo_i != core_port_pkg::AmoNone);
  // Atomics go out on AW and also expect an R beat
  assign uses_aw    = q_write_i | is_amo;
  assign uses_shift = ~q_write_i | is_amo;
  assign q_fire     = q_valid_i & q_ready_o;

  always_comb begin
    wfifo_in.data = q_data_i;
    wfifo_in.strb = q_strb_i;
    wfifo_in.lane = q_addr_i[AxiByteOffset-1:core_port_pkg::CoreByteOffset];
    unique case (q_amo_i)
      core_port_pkg::AmoSwap: axi.aw_atop = axi_defs_pkg::AtopSwap;
      core_port_pkg::AmoAdd: begin
        axi.aw_atop = {axi_defs_pkg::AtopAtomicLoad, axi_defs_pkg::AtopLittleEnd,
                       axi_defs_pkg::AtopAdd};
      end
      core_port_pkg::AmoAnd: begin
        // AND becomes a clear of the inverted operand
        wfifo_in.data = ~q_data_i;
        axi.aw_atop   = {axi_defs_pkg::AtopAtomicLoad, axi_defs_pkg::AtopLittleEnd,
                         axi_defs_pkg::AtopClr};
      end
      core_port_pkg::AmoOr: begin
        axi.aw_atop = {axi_defs_pkg::AtopAtomicLoad, axi_defs_pkg::AtopLittleEnd,
                       axi_defs_pkg::AtopSet};
      end
      core_port_pkg::AmoXor: begin
        axi.aw_atop = {axi_defs_pkg::AtopAtomicLoad, axi_defs_pkg::AtopLittleEnd,
                       axi_defs_pkg::AtopEor};
      end
      core_port_pkg::AmoMax: begin
        axi.aw_atop = {axi_defs_pkg::AtopAtomicLoad, axi_defs_pkg::AtopLittleEnd,
                       axi_defs_pkg::AtopSmax};
      end
      core_port_pkg::AmoMaxu: begin
        axi.aw_atop = {axi_defs_pkg::AtopAtomicLoad, axi_defs_pkg::AtopLittleEnd,
                       axi_defs_pkg::AtopUmax};
      end
      core_port_pkg::AmoMin: begin
        axi.aw_atop = {axi_defs_pkg::AtopAtomicLoad, axi_defs_pkg::AtopLittleEnd,
                       axi_defs_pkg::AtopSmin};
      end
      core_port_pkg::AmoMinu: begin
        axi.aw_atop = {axi_defs_pkg::AtopAtomicLoad, axi_defs_pkg::AtopLittleEnd,
                       axi_defs_pkg::AtopUmin};
      end
      default: axi.aw_atop = '0;
    endcase
  end

  sync_fifo #(
    .Depth (WriteFifoDepth),
    .Width ($bits(wentry_t))
  ) u_wdata_fifo (
    .clk_i,
    .arst_n_i,
    .push_i  (q_fire & uses_aw),
    .data_i  (wfifo_in),
    .pop_i   (axi.w_valid & axi.w_ready),
    .data_o  (wfifo_out),
    .full_o  (wfifo_full),
    .empty_o (wfifo_empty)
  );

  // Holds the lane of each outstanding read until its last beat
  sync_fifo #(
    .Depth (ReadFifoDepth),
    .Width (LaneBits)
  ) u_rshift_fifo (
    .clk_i,
    .arst_n_i,
    .push_i  (q_fire & uses_shift),
    .data_i  (q_addr_i[AxiByteOffset-1:core_port_pkg::CoreByteOffset]),
    .pop_i   (axi.r_valid & axi.r_ready & axi.r_last),
    .data_o  (r_lane),
    .full_o  (rfifo_full),
    .empty_o ()
  );

  assign axi.aw_addr  = q_addr_i;
  assign axi.aw_size  = q_size_i;
  assign axi.aw_len   = '0;
  assign axi.aw_burst = axi_defs_pkg::BurstIncr;
  assign axi.aw_valid = q_valid_i & uses_aw & ~wfifo_full & ~(is_amo & rfifo_full);

  assign axi.w_data  = axi_defs_pkg::axi_data_t'(wfifo_out.data)
                       << ($bits(core_port_pkg::core_data_t) * wfifo_out.lane);
  assign axi.w_strb  = axi_defs_pkg::axi_strb_t'(wfifo_out.strb)
                       << ($bits(core_port_pkg::core_strb_t) * wfifo_out.lane);
  assign axi.w_last  = 1'b1;
  assign axi.w_valid = ~wfifo_empty;

  assign axi.b_ready = 1'b1;

  assign axi.ar_addr  = q_addr_i;
  assign axi.ar_size  = q_size_i;
  assign axi.ar_len   = q_rlen_i;
  assign axi.ar_burst = axi_defs_pkg::BurstIncr;
  assign axi.ar_valid = q_valid_i & ~uses_aw & ~rfifo_full;

  assign q_ready_o = (axi.aw_valid & axi.aw_ready) | (axi.ar_valid & axi.ar_ready);

  assign p_data_o  = core_port_pkg::core_data_t'(axi.r_data
                     >> ($bits(core_port_pkg::core_data_t) * r_lane));
  assign p_error_o = !(axi.r_resp inside {axi_defs_pkg::RespOkay, axi_defs_pkg::RespExokay});
  assign p_last_o  = axi.r_last;
  assign p_valid_o = axi.r_valid;
  assign axi.r_ready = p_ready_i;

  a_no_write_burst : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (q_fire && uses_aw) |-> (q_rlen_i == '0));

endmodule

`default_nettype wire

// File: src/core_axi_subsystem.sv
`default_nettype none
// Core memory port subsystem
// Adapter drives an AXI4 bus into a local atomic-capable memory

module core_axi_subsystem #(
  parameter int unsigned WriteFifoDepth = 2,
  parameter int unsigned ReadFifoDepth  = 2,
  parameter int unsigned MemWords       = 64
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  axi_defs_pkg::axi_addr_t   q_addr_i,
  input  logic                      q_write_i,
  input  core_port_pkg::amo_op_t    q_amo_i,
  input  core_port_pkg::core_data_t q_data_i,
  input  core_port_pkg::core_strb_t q_strb_i,
  input  axi_defs_pkg::axi_size_t   q_size_i,
  input  axi_defs_pkg::axi_len_t    q_rlen_i,
  input  logic                      q_valid_i,
  output logic                      q_ready_o,
  output core_port_pkg::core_data_t p_data_o,
  output logic                      p_error_o,
  output logic                      p_last_o,
  output logic                      p_valid_o,
  input  logic                      p_ready_i
);

  axi_bus_if axi ();

  axi_master_adapter #(
    .WriteFifoDepth (WriteFifoDepth),
    .ReadFifoDepth  (ReadFifoDepth)
  ) u_adapter (
    .clk_i,
    .arst_n_i,
    .q_addr_i,
    .q_write_i,
    .q_amo_i,
    .q_data_i,
    .q_strb_i,
    .q_size_i,
    .q_rlen_i,
    .q_valid_i,
    .q_ready_o,
    .p_data_o,
    .p_error_o,
    .p_last_o,
    .p_valid_o,
    .p_ready_i,
    .axi       (axi)
  );

  axi_atomic_mem #(
    .Words (MemWords)
  ) u_mem (
    .clk_i,
    .arst_n_i,
    .axi   (axi)
  );

endmodule

`default_nettype wire

// File: src/core_port_pkg.sv
`default_nettype none
// Core memory port definitions
// Payload widths and the RISC-V atomic opcode encoding

package core_port_pkg;

  typedef logic [31:0] core_data_t;
  typedef logic [3:0]  core_strb_t;

  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9
  } amo_op_t;

  // Byte address bits inside one core word
  localparam int unsigned CoreByteOffset = 2;

endpackage

`default_nettype wire

// File: src/sync_fifo.sv
`default_nettype none
// Synchronous first-word-fall-through FIFO
// Register array with a fill counter, head word always visible on data_o

module sync_fifo #(
  parameter int unsigned Depth = 2,
  parameter int unsigned Width = 8
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             push_i,
  input  logic [Width-1:0] data_i,
  input  logic             pop_i,
  output logic [Width-1:0] data_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  logic [Width-1:0]    mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntWidth'(push_i) - CntWidth'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0);

  a_no_overflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    push_i |-> !full_o);
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

// File: tests/tb_core_axi_subsystem.sv
`default_nettype none
// Testbench for the core to AXI subsystem
// Directed and random requests checked in order against a shadow-memory model

module tb_core_axi_subsystem;

  localparam int unsigned MemWords      = 64;
  localparam int unsigned WordTests     = 16;
  localparam int unsigned StrobeTests   = 8;
  localparam int unsigned BurstBeats    = 8;
  localparam int unsigned AmoTests      = 9;
  localparam int unsigned RangeReqs     = 5;
  localparam int unsigned RandomTests   = 300;
  localparam int unsigned NumRequests   = 2 * WordTests + 3 * StrobeTests
                                          + 2 * (BurstBeats + 1) + 3 * AmoTests
                                          + RangeReqs + RandomTests;
  localparam int unsigned TimeoutCycles = 40 * NumRequests + 200;

  logic                      clk_i;
  logic                      arst_n_i;
  axi_defs_pkg::axi_addr_t   q_addr_i;
  logic                      q_write_i;
  core_port_pkg::amo_op_t    q_amo_i;
  core_port_pkg::core_data_t q_data_i;
  core_port_pkg::core_strb_t q_strb_i;
  axi_defs_pkg::axi_size_t   q_size_i;
  axi_defs_pkg::axi_len_t    q_rlen_i;
  logic                      q_valid_i;
  logic                      q_ready_o;
  core_port_pkg::core_data_t p_data_o;
  logic                      p_error_o;
  logic                      p_last_o;
  logic                      p_valid_o;
  logic                      p_ready_i;

  logic [15:0]               lfsr_q = 16'd94;
  int unsigned               cycle_cnt = 0;
  logic                      stall_on;
  string                     cur_test;
  core_port_pkg::core_data_t shadow [MemWords * 2];

  // Expected responses in issue order
  core_port_pkg::core_data_t exp_data_q [$];
  logic                      exp_err_q [$];
  logic                      exp_last_q [$];
  string                     exp_name_q [$];
  core_port_pkg::core_data_t exp_data;
  logic                      exp_err;
  logic                      exp_last;
  string                     exp_name;

  core_axi_subsystem #(
    .MemWords (MemWords)
  ) u_core_axi_subsystem (
    .clk_i,
    .arst_n_i,
    .q_addr_i,
    .q_write_i,
    .q_amo_i,
    .q_data_i,
    .q_strb_i,
    .q_size_i,
    .q_rlen_i,
    .q_valid_i,
    .q_ready_o,
    .p_data_o,
    .p_error_o,
    .p_last_o,
    .p_valid_o,
    .p_ready_i
  );

  always #50 clk_i = ~clk_i;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic axi_defs_pkg::axi_addr_t rand_addr(input logic allow_oor);
    axi_defs_pkg::axi_addr_t a;
    a = axi_defs_pkg::axi_addr_t'(rand_bits(7)) << 2;
    if (allow_oor && rand_bits(4) == 0) begin
      a = a + axi_defs_pkg::axi_addr_t'(MemWords * 8);
    end
    return a;
  endfunction

  function automatic core_port_pkg::core_data_t merge_bytes(
      input core_port_pkg::core_data_t old_v, input core_port_pkg::core_data_t new_v,
      input core_port_pkg::core_strb_t strb);
    core_port_pkg::core_data_t res;
    for (int b = 0; b < 4; b++) begin
      res[b*8 +: 8] = strb[b] ? new_v[b*8 +: 8] : old_v[b*8 +: 8];
    end
    return res;
  endfunction

  // RISC-V AMO result from the old word and the operand
  function automatic core_port_pkg::core_data_t amo_ref(input core_port_pkg::amo_op_t op,
      input core_port_pkg::core_data_t old_v, input core_port_pkg::core_data_t opd);
    core_port_pkg::core_data_t res;
    case (op)
      core_port_pkg::AmoAdd:  res = old_v + opd;
      core_port_pkg::AmoAnd:  res = old_v & opd;
      core_port_pkg::AmoOr:   res = old_v | opd;
      core_port_pkg::AmoXor:  res = old_v ^ opd;
      core_port_pkg::AmoMax:  res = ($signed(old_v) > $signed(opd)) ? old_v : opd;
      core_port_pkg::AmoMaxu: res = (old_v > opd) ? old_v : opd;
      core_port_pkg::AmoMin:  res = ($signed(old_v) < $signed(opd)) ? old_v : opd;
      core_port_pkg::AmoMinu: res = (old_v < opd) ? old_v : opd;
      default:                res = opd;
    endcase
    return res;
  endfunction

  function automatic void expect_beat(input core_port_pkg::core_data_t data,
      input logic err, input logic last);
    exp_data_q.push_back(data);
    exp_err_q.push_back(err);
    exp_last_q.push_back(last);
    exp_name_q.push_back(cur_test);
  endfunction

  function automatic void model_req(input axi_defs_pkg::axi_addr_t addr, input logic write,
      input core_port_pkg::amo_op_t amo, input core_port_pkg::core_data_t data,
      input core_port_pkg::core_strb_t strb, input axi_defs_pkg::axi_len_t rlen);
    int unsigned               mword;
    int unsigned               widx;
    int unsigned               lane;
    core_port_pkg::core_data_t old_v;
    mword = addr >> 3;
    widx  = addr >> 2;
    lane  = addr[2] ? 1 : 0;
    if (amo != core_port_pkg::AmoNone) begin
      old_v = (mword < MemWords) ? shadow[widx] : '0;
      expect_beat(old_v, mword >= MemWords, 1'b1);
      if (mword < MemWords) begin
        shadow[widx] = merge_bytes(old_v, amo_ref(amo, old_v, data), strb);
      end
    end else if (write) begin
      if (mword < MemWords) begin
        shadow[widx] = merge_bytes(shadow[widx], data, strb);
      end
    end else begin
      // Each beat is the next 64-bit word in the same 32-bit lane
      for (int k = 0; k <= int'(rlen); k++) begin
        if (mword + k < MemWords) begin
          expect_beat(shadow[2 * (mword + k) + lane], 1'b0, k == int'(rlen));
        end else begin
          expect_beat('0, 1'b1, k == int'(rlen));
        end
      end
    end
  endfunction

  task automatic drive_stall();
    if (stall_on) begin
      p_ready_i = (rand_bits(2) != 0);
    end else begin
      p_ready_i = 1'b1;
    end
  endtask

  task automatic send_req(input axi_defs_pkg::axi_addr_t addr, input logic write,
      input core_port_pkg::amo_op_t amo, input core_port_pkg::core_data_t data,
      input core_port_pkg::core_strb_t strb, input axi_defs_pkg::axi_len_t rlen);
    logic accepted;
    q_addr_i  = addr;
    q_write_i = write;
    q_amo_i   = amo;
    q_data_i  = data;
    q_strb_i  = strb;
    q_rlen_i  = rlen;
    q_valid_i = 1'b1;
    accepted  = 1'b0;
    while (!accepted) begin
      drive_stall();
      @(posedge clk_i);
      accepted = q_ready_o;
      @(negedge clk_i);
    end
    q_valid_i = 1'b0;
    model_req(addr, write, amo, data, strb, rlen);
  endtask

  // Plain writes may overtake the later beats of a burst
  task automatic drain_responses();
    while (exp_data_q.size() != 0) begin
      drive_stall();
      @(posedge clk_i);
      @(negedge clk_i);
    end
  endtask

  always @(posedge clk_i) begin
    if (arst_n_i && p_valid_o && p_ready_i) begin
      assert (exp_data_q.size() != 0) else begin
        $display("Response arrived with no request outstanding");
        $display("FAIL: see errors above");
        $fatal(1);
      end
      exp_data = exp_data_q.pop_front();
      exp_err  = exp_err_q.pop_front();
      exp_last = exp_last_q.pop_front();
      exp_name = exp_name_q.pop_front();
      assert (p_error_o == exp_err) else begin
        $display("FAIL %s error: expected %0b actual %0b", exp_name, exp_err, p_error_o);
        $display("FAIL: see errors above");
        $fatal(1);
      end
      assert (p_data_o == exp_data) else begin
        $display("FAIL %s data: expected %h actual %h", exp_name, exp_data, p_data_o);
        $display("FAIL: see errors above");
        $fatal(1);
      end
      assert (p_last_o == exp_last) else begin
        $display("FAIL %s last: expected %0b actual %0b", exp_name, exp_last, p_last_o);
        $display("FAIL: see errors above");
        $fatal(1);
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout after %0d cycles, %0d responses still expected",
               cycle_cnt, exp_data_q.size());
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  initial begin
    axi_defs_pkg::axi_addr_t   addr;
    axi_defs_pkg::axi_addr_t   base;
    core_port_pkg::core_data_t data;
    core_port_pkg::core_strb_t strb;
    axi_defs_pkg::axi_len_t    rlen;
    core_port_pkg::amo_op_t    amo;
    core_port_pkg::amo_op_t    amo_ops [AmoTests];
    logic [31:0]               sel;
    clk_i     = 1'b0;
    arst_n_i  = 1'b0;
    q_addr_i  = '0;
    q_write_i = 1'b0;
    q_amo_i   = core_port_pkg::AmoNone;
    q_data_i  = '0;
    q_strb_i  = '0;
    q_size_i  = 3'd2;
    q_rlen_i  = '0;
    q_valid_i = 1'b0;
    p_ready_i = 1'b0;
    stall_on  = 1'b0;
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
    amo_ops = '{core_port_pkg::AmoSwap, core_port_pkg::AmoAdd, core_port_pkg::AmoAnd,
                core_port_pkg::AmoOr, core_port_pkg::AmoXor, core_port_pkg::AmoMax,
                core_port_pkg::AmoMaxu, core_port_pkg::AmoMin, core_port_pkg::AmoMinu};
    repeat (10) @(negedge clk_i);
    arst_n_i  = 1'b1;
    p_ready_i = 1'b1;

    // Idle port after reset
    cur_test = "reset";
    @(negedge clk_i);
    assert (!q_ready_o && !p_valid_o) else begin
      $display("FAIL %s q_ready/p_valid: expected 0/0 actual %0b/%0b",
               cur_test, q_ready_o, p_valid_o);
      $display("FAIL: see errors above");
      $fatal(1);
    end

    cur_test = "word_readback";
    for (int i = 0; i < WordTests; i++) begin
      addr = rand_addr(1'b0);
      data = rand_bits(32);
      drain_responses();
      send_req(addr, 1'b1, core_port_pkg::AmoNone, data, 4'hF, 8'd0);
      send_req(addr, 1'b0, core_port_pkg::AmoNone, '0, '0, 8'd0);
    end

    cur_test = "byte_strobe";
    for (int i = 0; i < StrobeTests; i++) begin
      addr = rand_addr(1'b0);
      data = rand_bits(32);
      drain_responses();
      send_req(addr, 1'b1, core_port_pkg::AmoNone, data, 4'hF, 8'd0);
      data = rand_bits(32);
      strb = 4'(rand_bits(4));
      send_req(addr, 1'b1, core_port_pkg::AmoNone, data, strb, 8'd0);
      send_req(addr, 1'b0, core_port_pkg::AmoNone, '0, '0, 8'd0);
    end

    // One burst per lane with the second ending on the last word
    cur_test = "burst_read";
    for (int b = 0; b < 2; b++) begin
      base = (b == 0) ? 32'h040 : 32'h1C4;
      drain_responses();
      for (int k = 0; k < BurstBeats; k++) begin
        data = rand_bits(32);
        send_req(base + axi_defs_pkg::axi_addr_t'(k * 8), 1'b1, core_port_pkg::AmoNone,
                 data, 4'hF, 8'd0);
      end
      send_req(base, 1'b0, core_port_pkg::AmoNone, '0, '0, 8'(BurstBeats - 1));
    end

    cur_test = "atomic_ops";
    for (int i = 0; i < AmoTests; i++) begin
      addr = rand_addr(1'b0);
      data = rand_bits(32);
      drain_responses();
      send_req(addr, 1'b1, core_port_pkg::AmoNone, data, 4'hF, 8'd0);
      data = rand_bits(32);
      send_req(addr, 1'b1, amo_ops[i], data, 4'hF, 8'd0);
      send_req(addr, 1'b0, core_port_pkg::AmoNone, '0, '0, 8'd0);
    end

    // 0x204 would alias word 0 lane 1 if the range check failed
    cur_test = "out_of_range";
    drain_responses();
    send_req(32'h204, 1'b1, core_port_pkg::AmoNone, 32'hA5A5_0F0F, 4'hF, 8'd0);
    send_req(32'h204, 1'b0, core_port_pkg::AmoNone, '0, '0, 8'd0);
    send_req(32'h204, 1'b1, core_port_pkg::AmoAdd, 32'h0000_0001, 4'hF, 8'd0);
    send_req(32'h3F8, 1'b0, core_port_pkg::AmoNone, '0, '0, 8'd2);
    send_req(32'h004, 1'b0, core_port_pkg::AmoNone, '0, '0, 8'd0);

    cur_test = "random_mix";
    stall_on = 1'b1;
    for (int i = 0; i < RandomTests; i++) begin
      sel  = rand_bits(3);
      addr = rand_addr(1'b1);
      data = rand_bits(32);
      if (sel < 3) begin
        rlen = 8'(rand_bits(2));
        send_req(addr, 1'b0, core_port_pkg::AmoNone, '0, '0, rlen);
      end else if (sel < 5) begin
        strb = 4'(rand_bits(4));
        drain_responses();
        send_req(addr, 1'b1, core_port_pkg::AmoNone, data, strb, 8'd0);
      end else begin
        amo = core_port_pkg::amo_op_t'(4'(rand_bits(4) % 9 + 1));
        send_req(addr, 1'b1, amo, data, 4'hF, 8'd0);
      end
    end
    drain_responses();
    stall_on  = 1'b0;
    p_ready_i = 1'b1;
    repeat (4) @(negedge clk_i);

    if (exp_data_q.size() == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("%0d responses never arrived", exp_data_q.size());
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire
